//--- Makefile
TOP := tb_aes_decrypt

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f

run: compile
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

//--- all.f
design/aes_pkg.sv
design/inv_mix_unit.sv
design/key_expander.sv
design/round_sequencer.sv
design/state_datapath.sv
design/aes_decrypt.sv
verif/tb_aes_decrypt.sv

//--- design/aes_decrypt.sv
// AES-128 decryption core
module aes_decrypt
	import aes_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RESET,
	input  logic                  start,
	input  round_key_t            key,
	input  logic [BLOCK_BITS-1:0] ciphertext,
	output logic                  done,
	output logic [BLOCK_BITS-1:0] plaintext
);

	seq_ctrl_t  ctrl;
	round_key_t round_key;
	logic       keys_ready;
	aes_state_u block;

	round_sequencer u_sequencer (
		.CLK        (CLK),
		.RESET      (RESET),
		.start      (start),
		.keys_ready (keys_ready),
		.ctrl       (ctrl),
		.done       (done)
	);

	key_expander u_key_expander (
		.CLK        (CLK),
		.RESET      (RESET),
		.key_start  (ctrl.key_start),
		.key        (key),
		.key_idx    (ctrl.key_idx),
		.round_key  (round_key),
		.keys_ready (keys_ready)
	);

	state_datapath u_datapath (
		.CLK        (CLK),
		.RESET      (RESET),
		.ctrl       (ctrl),
		.ciphertext (ciphertext),
		.round_key  (round_key),
		.block      (block)
	);

	// result is read straight from the state register
	assign plaintext = block.flat;

endmodule

//--- design/aes_pkg.sv
// AES-128 shared definitions
package aes_pkg;

	// block geometry
	localparam int BLOCK_BITS = 128;
	localparam int COL_BITS   = 32;
	localparam int NUM_COLS   = 4;
	localparam int NUM_ROUNDS = 10;
	localparam int NUM_KEYS   = NUM_ROUNDS + 1;

	// s-box affine constants and first round constant
	localparam logic [7:0] SBOX_AFFINE     = 8'h63;
	localparam logic [7:0] SBOX_INV_AFFINE = 8'h05;
	localparam logic [7:0] RCON_FIRST      = 8'h01;

	// reduction term of x^8 + x^4 + x^3 + x + 1
	localparam logic [7:0] GF_POLY = 8'h1b;

	typedef logic [BLOCK_BITS-1:0] round_key_t;
	typedef logic [3:0] key_idx_t;
	typedef logic [1:0] col_idx_t;

	// column 0 sits in the top word
	typedef union packed {
		logic [BLOCK_BITS-1:0] flat;
		logic [0:NUM_COLS-1][COL_BITS-1:0] cols;
	} aes_state_u;

	typedef enum logic [1:0] {
		OP_ADD_KEY   = 2'd0,
		OP_INV_SHIFT = 2'd1,
		OP_INV_SUB   = 2'd2,
		OP_INV_MIX   = 2'd3
	} step_op_t;

	// per-cycle datapath control
	typedef struct packed {
		logic     load_block;
		logic     key_start;
		step_op_t op;
		logic     state_we;
		col_idx_t col;
		logic     col_we;
		key_idx_t key_idx;
	} seq_ctrl_t;

	// xtime
	function automatic logic [7:0] gf_mul2(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? GF_POLY : 8'h00);
	endfunction

	// shift-and-add product in GF(2^8)
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] acc;
		logic [7:0] term;
		acc = 8'h00;
		term = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ term;
			term = gf_mul2(term);
		end
		return acc;
	endfunction

	// a^254, which also maps zero to zero
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] pow;
		logic [7:0] acc;
		pow = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++)
		begin
			pow = gf_mul(pow, pow);
			acc = gf_mul(acc, pow);
		end
		return acc;
	endfunction

	function automatic logic [7:0] sbox_fwd(input logic [7:0] a);
		logic [7:0] b;
		b = gf_inv(a);
		return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
			^ {b[3:0], b[7:4]} ^ SBOX_AFFINE;
	endfunction

	// undo the affine map first, then invert
	function automatic logic [7:0] sbox_inv(input logic [7:0] a);
		logic [7:0] b;
		b = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ SBOX_INV_AFFINE;
		return gf_inv(b);
	endfunction

	// one column times the 0e 0b 0d 09 circulant
	function automatic logic [COL_BITS-1:0] inv_mix_col(input logic [COL_BITS-1:0] col);
		logic [7:0] a [NUM_COLS];
		logic [COL_BITS-1:0] res;
		res = '0;
		for (int r = 0; r < NUM_COLS; r++)
			a[r] = col[COL_BITS-1-8*r -: 8];
		for (int r = 0; r < NUM_COLS; r++)
		begin
			res[COL_BITS-1-8*r -: 8] = gf_mul(a[r], 8'h0e)
				^ gf_mul(a[(r + 1) % NUM_COLS], 8'h0b)
				^ gf_mul(a[(r + 2) % NUM_COLS], 8'h0d)
				^ gf_mul(a[(r + 3) % NUM_COLS], 8'h09);
		end
		return res;
	endfunction

endpackage

//--- design/inv_mix_unit.sv
// InvMixColumns column unit
module inv_mix_unit
	import aes_pkg::*;
(
	input  logic                CLK,
	input  logic                RESET,
	input  col_idx_t            col,
	input  logic                col_we,
	input  logic [COL_BITS-1:0] column_in,
	output aes_state_u          mixed
);

	logic [COL_BITS-1:0] column_out;

	// single multiplier shared by all four columns
	assign column_out = inv_mix_col(column_in);

	// result parks in the slot of the column it came from
	always_ff @(posedge CLK)
	begin
		if (RESET)
			mixed.flat <= '0;
		else if (col_we)
			mixed.cols[col] <= column_out;
	end

endmodule

//--- design/key_expander.sv
// AES-128 round key store
module key_expander
	import aes_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       key_start,
	input  round_key_t key,
	input  key_idx_t   key_idx,
	output round_key_t round_key,
	output logic       keys_ready
);

	round_key_t          key_store [NUM_KEYS];
	key_idx_t            fill_idx;
	logic                busy;
	logic [7:0]          rcon;
	round_key_t          prev_key;
	round_key_t          next_key;
	logic [COL_BITS-1:0] rot_word;
	logic [COL_BITS-1:0] sub_word;

	// newest stored key feeds the next derivation
	assign prev_key = key_store[fill_idx];

	always_comb
	begin
		rot_word = {prev_key[23:0], prev_key[31:24]};
		for (int b = 0; b < 4; b++)
			sub_word[8*b +: 8] = sbox_fwd(rot_word[8*b +: 8]);
		next_key[127:96] = prev_key[127:96] ^ sub_word ^ {rcon, 24'h000000};
		next_key[95:64]  = prev_key[95:64] ^ next_key[127:96];
		next_key[63:32]  = prev_key[63:32] ^ next_key[95:64];
		next_key[31:0]   = prev_key[31:0] ^ next_key[63:32];
	end

	// fill counter and round constant
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			busy       <= 1'b0;
			keys_ready <= 1'b0;
			fill_idx   <= '0;
			rcon       <= RCON_FIRST;
		end
		else if (key_start)
		begin
			busy       <= 1'b1;
			keys_ready <= 1'b0;
			fill_idx   <= '0;
			rcon       <= RCON_FIRST;
		end
		else if (busy)
		begin
			fill_idx <= fill_idx + 1'b1;
			rcon     <= gf_mul2(rcon);
			// key 10 lands on this edge
			if (fill_idx == key_idx_t'(NUM_ROUNDS - 1))
			begin
				busy       <= 1'b0;
				keys_ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (key_start)
			key_store[0] <= key;
		else if (busy)
			key_store[fill_idx + 1'b1] <= next_key;
	end

	assign round_key = key_store[key_idx];

endmodule

//--- design/round_sequencer.sv
// AES-128 decryption round sequencer
module round_sequencer
	import aes_pkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  logic      start,
	input  logic      keys_ready,
	output seq_ctrl_t ctrl,
	output logic      done
);

	typedef enum logic [3:0] {
		PH_IDLE,
		PH_EXPAND,
		PH_FIRST_KEY,
		PH_SHIFT,
		PH_SUB,
		PH_ADD_KEY,
		PH_MIX,
		PH_MIX_WRITE,
		PH_FINISH
	} phase_t;

	phase_t   phase;
	phase_t   phase_next;
	// also the round key index, counts down in decryption order
	key_idx_t round_q;
	col_idx_t col_q;

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			phase   <= PH_IDLE;
			round_q <= '0;
			col_q   <= '0;
		end
		else
		begin
			phase <= phase_next;
			if (phase == PH_IDLE && start)
				round_q <= key_idx_t'(NUM_ROUNDS);
			else if ((phase == PH_FIRST_KEY || phase == PH_ADD_KEY) && round_q != '0)
				round_q <= round_q - 1'b1;
			// wraps back to column 0 after the last one
			if (phase == PH_MIX)
				col_q <= col_q + 1'b1;
		end
	end

	always_comb
	begin
		phase_next   = phase;
		ctrl         = '0;
		ctrl.op      = OP_ADD_KEY;
		ctrl.col     = col_q;
		ctrl.key_idx = round_q;
		case (phase)
			PH_IDLE:
			begin
				// key and block are captured on the accepting edge
				ctrl.load_block = start;
				ctrl.key_start  = start;
				if (start)
					phase_next = PH_EXPAND;
			end
			PH_EXPAND:
				if (keys_ready)
					phase_next = PH_FIRST_KEY;
			PH_FIRST_KEY:
			begin
				ctrl.state_we = 1'b1;
				phase_next    = PH_SHIFT;
			end
			PH_SHIFT:
			begin
				ctrl.op       = OP_INV_SHIFT;
				ctrl.state_we = 1'b1;
				phase_next    = PH_SUB;
			end
			PH_SUB:
			begin
				ctrl.op       = OP_INV_SUB;
				ctrl.state_we = 1'b1;
				phase_next    = PH_ADD_KEY;
			end
			PH_ADD_KEY:
			begin
				ctrl.state_we = 1'b1;
				// final round has no mix
				phase_next    = (round_q == '0) ? PH_FINISH : PH_MIX;
			end
			PH_MIX:
			begin
				ctrl.col_we = 1'b1;
				if (col_q == col_idx_t'(NUM_COLS - 1))
					phase_next = PH_MIX_WRITE;
			end
			PH_MIX_WRITE:
			begin
				ctrl.op       = OP_INV_MIX;
				ctrl.state_we = 1'b1;
				phase_next    = PH_SHIFT;
			end
			PH_FINISH:
				if (!start)
					phase_next = PH_IDLE;
			default:
				phase_next = PH_IDLE;
		endcase
	end

	assign done = (phase == PH_FINISH);

endmodule

//--- design/state_datapath.sv
// AES-128 decryption state datapath
module state_datapath
	import aes_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RESET,
	input  seq_ctrl_t             ctrl,
	input  logic [BLOCK_BITS-1:0] ciphertext,
	input  round_key_t            round_key,
	output aes_state_u            block
);

	aes_state_u shifted;
	aes_state_u substituted;
	aes_state_u mixed;
	aes_state_u next_block;

	inv_mix_unit u_inv_mix (
		.CLK       (CLK),
		.RESET     (RESET),
		.col       (ctrl.col),
		.col_we    (ctrl.col_we),
		.column_in (block.cols[ctrl.col]),
		.mixed     (mixed)
	);

	// row r rotates right by r columns
	always_comb
	begin
		for (int c = 0; c < NUM_COLS; c++)
			for (int r = 0; r < NUM_COLS; r++)
				shifted.cols[c][COL_BITS-1-8*r -: 8] =
					block.cols[(c - r + NUM_COLS) % NUM_COLS][COL_BITS-1-8*r -: 8];
	end

	always_comb
	begin
		for (int i = 0; i < BLOCK_BITS / 8; i++)
			substituted.flat[8*i +: 8] = sbox_inv(block.flat[8*i +: 8]);
	end

	always_comb
	begin
		case (ctrl.op)
			OP_ADD_KEY:   next_block.flat = block.flat ^ round_key;
			OP_INV_SHIFT: next_block = shifted;
			OP_INV_SUB:   next_block = substituted;
			default:      next_block = mixed;
		endcase
	end

	// ciphertext load wins over a step write
	always_ff @(posedge CLK)
	begin
		if (RESET)
			block.flat <= '0;
		else if (ctrl.load_block)
			block.flat <= ciphertext;
		else if (ctrl.state_we)
			block <= next_block;
	end

endmodule

//--- verif/tb_aes_decrypt.sv
// AES-128 decryption testbench
module tb_aes_decrypt
	import aes_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int QUIET_CYCLES   = 20;
	localparam int HOLD_CYCLES    = 10;

	// FIPS-197 appendix C.1
	localparam round_key_t            C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [BLOCK_BITS-1:0] C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [BLOCK_BITS-1:0] C1_PT  = 128'h00112233445566778899aabbccddeeff;

	// FIPS-197 appendix B
	localparam round_key_t            B_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [BLOCK_BITS-1:0] B_CT  = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam logic [BLOCK_BITS-1:0] B_PT  = 128'h3243f6a8885a308d313198a2e0370734;

	logic                  CLK;
	logic                  RESET;
	logic                  start;
	round_key_t            key;
	logic [BLOCK_BITS-1:0] ciphertext;
	logic                  done;
	logic [BLOCK_BITS-1:0] plaintext;

	logic [BLOCK_BITS-1:0] expected_pt;
	int                    error_count;
	int                    tests_run;
	int                    tests_failed;

	aes_decrypt u_dut (
		.CLK        (CLK),
		.RESET      (RESET),
		.start      (start),
		.key        (key),
		.ciphertext (ciphertext),
		.done       (done),
		.plaintext  (plaintext)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// first edge out of reset sees a quiet core and a cleared state
	assert property (@(posedge CLK) $fell(RESET) |-> !done && plaintext == '0
			&& !u_dut.ctrl.load_block && !u_dut.ctrl.key_start
			&& !u_dut.ctrl.state_we && !u_dut.ctrl.col_we)
	else
	begin
		error_count++;
		$display("core was not idle with a cleared state right after reset");
	end

	assert property (@(posedge CLK) disable iff (RESET) (!start && !done) |=> !done)
	else
	begin
		error_count++;
		$display("done rose although start was low");
	end

	// plaintext is compared on the first cycle of done
	assert property (@(posedge CLK) disable iff (RESET) $rose(done) |-> plaintext == expected_pt)
	else
	begin
		error_count++;
		$display("[FAIL] plaintext got %h expected %h", $sampled(plaintext), expected_pt);
	end

	assert property (@(posedge CLK) disable iff (RESET) (done && start) |=> done)
	else
	begin
		error_count++;
		$display("done dropped while start was still high");
	end

	assert property (@(posedge CLK) disable iff (RESET) (done && start) |=> $stable(plaintext))
	else
	begin
		error_count++;
		$display("[FAIL] plaintext changed to %h while done was held", $sampled(plaintext));
	end

	assert property (@(posedge CLK) disable iff (RESET) (done && !start) |=> !done)
	else
	begin
		error_count++;
		$display("done stayed high after start fell");
	end

	task automatic wait_for_done(input bit scramble);
		bit seen;
		seen = 1'b0;
		for (int cycles = 0; cycles < TIMEOUT_CYCLES && !seen; cycles++)
		begin
			@(posedge CLK);
			// noise after capture must not reach the result
			if (scramble)
			begin
				key        <= {$urandom, $urandom, $urandom, $urandom};
				ciphertext <= {$urandom, $urandom, $urandom, $urandom};
			end
			@(negedge CLK);
			seen = done;
		end
		if (!seen)
		begin
			error_count++;
			$display("done did not rise within %0d cycles", TIMEOUT_CYCLES);
		end
	endtask

	task automatic wait_for_idle();
		bit low;
		low = 1'b0;
		for (int cycles = 0; cycles < TIMEOUT_CYCLES && !low; cycles++)
		begin
			@(negedge CLK);
			low = !done;
		end
		if (!low)
		begin
			error_count++;
			$display("done did not fall within %0d cycles after start fell", TIMEOUT_CYCLES);
		end
	endtask

	// one full decryption with start held through done and then released
	task automatic decrypt_block(input round_key_t k, input logic [BLOCK_BITS-1:0] ct,
			input logic [BLOCK_BITS-1:0] pt, input bit scramble, input int hold);
		expected_pt = pt;
		@(posedge CLK);
		start      <= 1'b1;
		key        <= k;
		ciphertext <= ct;
		wait_for_done(scramble);
		repeat (hold) @(posedge CLK);
		@(posedge CLK);
		start <= 1'b0;
		wait_for_idle();
	endtask

	task automatic keep_start_low();
		for (int cycles = 0; cycles < QUIET_CYCLES; cycles++)
		begin
			@(posedge CLK);
			key        <= {$urandom, $urandom, $urandom, $urandom};
			ciphertext <= {$urandom, $urandom, $urandom, $urandom};
			@(negedge CLK);
			assert (!done)
			else
			begin
				error_count++;
				$display("[FAIL] done is %h while idle", done);
			end
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	initial
	begin
		int errors_before;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		expected_pt  = '0;
		void'($urandom(32'hfa89));
		RESET        = 1'b1;
		start        = 1'b0;
		key          = '0;
		ciphertext   = '0;
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;

		errors_before = error_count;
		keep_start_low();
		finish_test("idle after reset", errors_before);

		errors_before = error_count;
		decrypt_block(C1_KEY, C1_CT, C1_PT, 1'b0, 0);
		finish_test("appendix C.1 vector", errors_before);

		errors_before = error_count;
		decrypt_block(B_KEY, B_CT, B_PT, 1'b0, 0);
		finish_test("appendix B vector", errors_before);

		errors_before = error_count;
		decrypt_block(C1_KEY, C1_CT, C1_PT, 1'b1, 0);
		finish_test("inputs ignored while busy", errors_before);

		errors_before = error_count;
		decrypt_block(B_KEY, B_CT, B_PT, 1'b0, HOLD_CYCLES);
		finish_test("done held with start", errors_before);

		// key store must be rewritten between the two runs
		errors_before = error_count;
		decrypt_block(C1_KEY, C1_CT, C1_PT, 1'b0, 0);
		decrypt_block(B_KEY, B_CT, B_PT, 1'b0, 0);
		finish_test("back to back keys", errors_before);

		repeat (2) @(posedge CLK);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
